/* all.f */
rtl/pcs_pkg.sv
rtl/pcs_tx_encoder.sv
rtl/pcs_scrambler.sv
rtl/pcs_block_lock.sv
rtl/pcs_rx_decoder.sv
rtl/pcs_lane_top.sv
dv/pcs_lane_sva.sv
dv/pcs_lane_tb.sv

/* dv/pcs_lane_stimulus.txt */
# test rep txd txc rnd kept ovr
# rnd 1 fills data bytes randomly, kept 0 expects error back, ovr is forced rx header or ff
1 1 0707070707070707 ff 0 1 ff
1 1 0000000000000000 00 1 1 ff
1 1 55555555555555fb 01 1 1 ff
1 1 07070707070707fd ff 0 1 ff
1 1 070707070707fd11 fe 0 1 ff
1 1 0707070707fd2211 fc 0 1 ff
1 1 07070707fd332211 f8 0 1 ff
1 1 070707fd44332211 f0 0 1 ff
1 1 0707fd5544332211 e0 0 1 ff
1 1 07fd665544332211 c0 0 1 ff
1 1 fd77665544332211 80 0 1 ff
1 1 00000000000000fe 01 0 0 ff
2 5 0707070707070707 ff 0 1 ff
2 1 0707070707070707 ff 0 1 00
2 3 0707070707070707 ff 0 1 ff
2 1 0707070707070707 ff 0 1 03
2 4 0707070707070707 ff 0 1 ff
2 1 0707070707070707 ff 0 1 00
2 3 0707070707070707 ff 0 1 ff
3 70 0707070707070707 ff 0 1 ff
4 2 0707070707070707 ff 0 1 ff
4 1 a5a5a5a5a5a5a5fb 01 1 1 ff
4 2 0000000000000000 00 1 1 ff
4 1 07070707070707fd ff 0 1 ff
4 1 070707070707fdc1 fe 0 1 ff
4 1 0707070707fdd2c1 fc 0 1 ff
4 1 07070707fde3d2c1 f8 0 1 ff
4 1 070707fdf4e3d2c1 f0 0 1 ff
4 1 0707fd05f4e3d2c1 e0 0 1 ff
4 1 07fd1605f4e3d2c1 c0 0 1 ff
4 1 fd271605f4e3d2c1 80 0 1 ff
4 1 00000000000000fe 01 0 0 ff
4 1 0707fefd44332211 f0 0 0 ff
4 2 0707070707070707 ff 0 1 ff
5 2 0707070707070707 ff 0 1 ff
5 16 0707070707070707 ff 0 1 00
5 8 0707070707070707 ff 0 1 ff

/* dv/pcs_lane_tb.sv */
// Testbench for one PCS lane with serdes loopback, reference model and file stimulus
`timescale 1ns/1ns

module pcs_lane_tb
  import pcs_pkg::*;
();

  localparam logic [71:0] err_word = {{ctrl_width{1'b1}}, {ctrl_width{xgmii_error}}};
  localparam logic [63:0] idle_word = {ctrl_width{xgmii_idle}};

  logic                  gt_rxusrclk;
  logic                  gt_tx_reset;
  logic [data_width-1:0] xgmii_txd;
  logic [ctrl_width-1:0] xgmii_txc;
  logic [data_width-1:0] serdes_tx_data;
  logic [hdr_width-1:0]  serdes_tx_hdr;
  logic [data_width-1:0] serdes_rx_data;
  logic [hdr_width-1:0]  serdes_rx_hdr;
  logic                  serdes_rx_bitslip;
  logic                  rx_block_lock;
  logic [data_width-1:0] xgmii_rxd;
  logic [ctrl_width-1:0] xgmii_rxc;
  logic                  ovr_en;
  logic [hdr_width-1:0]  ovr_hdr;

  // Stimulus words with repeats already expanded
  int           st_test[$];
  logic [63:0]  st_d[$];
  logic [7:0]   st_c[$];
  logic [7:0]   st_ovr[$];
  bit           st_rnd[$];
  bit           st_kept[$];

  // Reference model state
  logic [65:0]  enc_q;
  logic [65:0]  tx_q;
  logic [57:0]  scr_state;
  bit           lock_q;
  bit           slip_q;
  int           good_cnt;
  int           win_cnt;
  int           bad_cnt;
  logic [72:0]  sent_q[$];
  logic [71:0]  rx_exp_q[$];

  string        cur_name;
  int           cur_test = 0;
  int           test_checks = 0;
  int           test_errors = 0;
  int           total_checks = 0;
  int           total_errors = 0;
  int           tests_run = 0;
  int           cycles = 0;
  int           limit = 0;

  pcs_lane_top #(
    .lock_good_count (lock_good_count),
    .lock_window     (lock_window),
    .lock_bad_limit  (lock_bad_limit)
  ) uut (
    .gt_rxusrclk       (gt_rxusrclk),
    .gt_tx_reset       (gt_tx_reset),
    .xgmii_txd         (xgmii_txd),
    .xgmii_txc         (xgmii_txc),
    .serdes_tx_data    (serdes_tx_data),
    .serdes_tx_hdr     (serdes_tx_hdr),
    .serdes_rx_data    (serdes_rx_data),
    .serdes_rx_hdr     (serdes_rx_hdr),
    .serdes_rx_bitslip (serdes_rx_bitslip),
    .rx_block_lock     (rx_block_lock),
    .xgmii_rxd         (xgmii_rxd),
    .xgmii_rxc         (xgmii_rxc)
  );

  // Loopback with an optional forced receive header
  assign serdes_rx_hdr  = ovr_en ? ovr_hdr : serdes_tx_hdr;
  assign serdes_rx_data = serdes_tx_data;

  initial begin
    gt_rxusrclk = 1'b0;
    forever #4 gt_rxusrclk = ~gt_rxusrclk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic string name_of_test(input int t);
    case (t)
      1:       return "tx_encode";
      2:       return "slip_search";
      3:       return "lock_acquire";
      4:       return "loopback";
      5:       return "lock_loss";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [71:0] expected,
                             input logic [71:0] actual);
    test_checks++;
    total_checks++;
    if (actual !== expected) begin
      test_errors++;
      total_errors++;
      $display("ERROR %s %s: expected %h, actual %h", cur_name, what, expected, actual);
    end
  endtask

  task automatic report_test();
    $display("Test %-12s %0d checks, %0d errors", cur_name, test_checks, test_errors);
    tests_run++;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic read_stimulus();
    int          fd;
    int          n;
    int          t;
    int          rep;
    int          rnd;
    int          kept;
    logic [63:0] d;
    logic [7:0]  c;
    logic [7:0]  ovr;
    string       line;
    fd = $fopen("dv/pcs_lane_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file dv/pcs_lane_stimulus.txt could not be opened");
      total_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%d %d %h %h %d %d %h", t, rep, d, c, rnd, kept, ovr);
      if (n == 7) begin
        for (int i = 0; i < rep; i++) begin
          st_test.push_back(t);
          st_d.push_back(d);
          st_c.push_back(c);
          st_rnd.push_back(rnd != 0);
          st_kept.push_back(kept != 0);
          st_ovr.push_back(ovr);
        end
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic logic [65:0] encode_block(input logic [63:0] d, input logic [7:0] c);
    logic [7:0]  term_codes [8];
    logic [63:0] p;
    int          k;
    bit          term_ok;
    term_codes = '{8'h87, 8'h99, 8'haa, 8'hb4, 8'hcc, 8'hd2, 8'he1, 8'hff};
    if (c == 8'h00) begin
      return {hdr_data, d};
    end
    if (c == 8'hff && d == idle_word) begin
      return {hdr_ctrl, 56'h0, 8'h1e};
    end
    if (c == 8'h01 && d[7:0] == xgmii_start) begin
      return {hdr_ctrl, d[63:8], 8'h78};
    end
    // Terminate sits in the lowest control lane
    k = 0;
    while (k < 7 && !c[k]) begin
      k++;
    end
    term_ok = (c == (8'hff << k)) && (d[8*k +: 8] == xgmii_term);
    for (int j = k + 1; j < 8; j++) begin
      term_ok = term_ok && (d[8*j +: 8] == xgmii_idle);
    end
    if (!term_ok) begin
      return {hdr_ctrl, {8{7'h1e}}, 8'h1e};
    end
    p = '0;
    p[7:0] = term_codes[k];
    for (int j = 0; j < k; j++) begin
      p[8 + 8*j +: 8] = d[8*j +: 8];
    end
    return {hdr_ctrl, p};
  endfunction

  // Line bit is payload bit xor the line bits 39 and 58 positions back
  task automatic scramble_block();
    logic [63:0] line;
    for (int i = 0; i < data_width; i++) begin
      line[i]   = enc_q[i] ^ scr_state[38] ^ scr_state[57];
      scr_state = {scr_state[56:0], line[i]};
    end
    tx_q = {enc_q[65:64], line};
  endtask

  task automatic update_lock(input logic [1:0] hdr);
    bit valid;
    valid = (hdr == hdr_data) || (hdr == hdr_ctrl);
    if (!lock_q) begin
      // A slip pulse lasts one cycle so the header right after it cannot slip again
      slip_q = !valid && !slip_q;
      good_cnt = valid ? good_cnt + 1 : 0;
      if (good_cnt == lock_good_count) begin
        lock_q  = 1'b1;
        win_cnt = 0;
        bad_cnt = 0;
      end
    end else begin
      slip_q = 1'b0;
      win_cnt++;
      bad_cnt += valid ? 0 : 1;
      if (bad_cnt == lock_bad_limit) begin
        lock_q   = 1'b0;
        good_cnt = 0;
      end else if (win_cnt == lock_window) begin
        win_cnt = 0;
        bad_cnt = 0;
      end
    end
  endtask

  // Checks outputs, drives the next word and advances the model by one edge
  task automatic run_step(input int idx);
    logic [63:0] d;
    logic [63:0] r;
    logic [7:0]  c;
    logic [7:0]  ovr;
    logic [1:0]  rx_hdr;
    logic [72:0] rx_word;
    bit          kept;
    bit          hdr_ok;
    check_value("serdes tx", {6'h0, tx_q}, {6'h0, serdes_tx_hdr, serdes_tx_data});
    check_value("block lock", lock_q, rx_block_lock);
    check_value("bitslip", slip_q, serdes_rx_bitslip);
    check_value("xgmii rx", rx_exp_q.pop_front(), {xgmii_rxc, xgmii_rxd});
    d    = idle_word;
    c    = 8'hff;
    ovr  = 8'hff;
    kept = 1'b1;
    if (idx < st_d.size()) begin
      d    = st_d[idx];
      c    = st_c[idx];
      ovr  = st_ovr[idx];
      kept = st_kept[idx];
      if (st_rnd[idx]) begin
        r = {$urandom, $urandom};
        if (c == 8'h00) begin
          d = r;
        end else begin
          d[63:8] = r[55:0];
        end
      end
    end
    xgmii_txd = d;
    xgmii_txc = c;
    ovr_en    = (ovr != 8'hff);
    ovr_hdr   = ovr[1:0];

    rx_hdr = (ovr != 8'hff) ? ovr[1:0] : tx_q[65:64];
    update_lock(rx_hdr);
    rx_word = sent_q.pop_front();
    hdr_ok  = (rx_hdr == tx_q[65:64]) && (rx_hdr == hdr_data || rx_hdr == hdr_ctrl);
    rx_exp_q.push_back((lock_q && hdr_ok && rx_word[72]) ? rx_word[71:0] : err_word);
    sent_q.push_back({kept, c, d});
    scramble_block();
    enc_q = encode_block(d, c);
  endtask

  // ----------------------------------------------------------
  // Timeout
  // ----------------------------------------------------------
  initial begin
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge gt_rxusrclk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(32'h946f));
    gt_tx_reset = 1'b1;
    xgmii_txd   = idle_word;
    xgmii_txc   = 8'hff;
    ovr_en      = 1'b0;
    ovr_hdr     = 2'b00;
    enc_q       = '0;
    tx_q        = '0;
    scr_state   = {scr_width{1'b1}};
    lock_q      = 1'b0;
    slip_q      = 1'b0;
    good_cnt    = 0;
    win_cnt     = 0;
    bad_cnt     = 0;
    // Two blocks from reset precede the first real word on each pipeline
    repeat (2) begin
      sent_q.push_back('0);
      rx_exp_q.push_back(err_word);
    end
    read_stimulus();
    limit = st_d.size() + 2 * lock_good_count + 50;

    repeat (10) @(posedge gt_rxusrclk);
    @(negedge gt_rxusrclk);
    cur_name = "reset";
    check_value("block lock", 0, rx_block_lock);
    check_value("bitslip", 0, serdes_rx_bitslip);
    check_value("xgmii rx", err_word, {xgmii_rxc, xgmii_rxd});
    check_value("serdes tx", 0, {serdes_tx_hdr, serdes_tx_data});
    report_test();
    gt_tx_reset = 1'b0;

    for (int idx = 0; idx < st_d.size(); idx++) begin
      if (st_test[idx] != cur_test) begin
        if (idx > 0) begin
          report_test();
        end
        cur_test = st_test[idx];
        cur_name = name_of_test(cur_test);
      end
      run_step(idx);
      @(negedge gt_rxusrclk);
    end
    // Flush the pipeline with idles
    for (int idx = 0; idx < 5; idx++) begin
      run_step(st_d.size() + idx);
      @(negedge gt_rxusrclk);
    end
    // The last test ends with the lane out of lock
    check_value("lock after bad window", 0, rx_block_lock);
    report_test();

    if (uut.u_block_lock.u_lane_sva.fail_count != 0) begin
      $display("Bound assertions on block lock failed %0d times",
               uut.u_block_lock.u_lane_sva.fail_count);
      total_errors += uut.u_block_lock.u_lane_sva.fail_count;
    end

    $display("Done: %0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* dv/pcs_lane_sva.sv */
// Assertions on block lock and bitslip behavior bound into the lock FSM
`timescale 1ns/1ns

module pcs_lane_sva
  import pcs_pkg::*;
#(
  parameter int lock_good_count = pcs_pkg::lock_good_count
) (
  input logic gt_rxusrclk,
  input logic gt_tx_reset,
  input logic rx_block_lock,
  input logic serdes_rx_bitslip
);

  // Saturating count of clock edges since reset was released
  logic [15:0] since_reset;

  // Number of failed assertions
  int fail_count = 0;

  always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
    if (gt_tx_reset) begin
      since_reset <= '0;
    end else if (since_reset != '1) begin
      since_reset <= since_reset + 1'b1;
    end
  end

  no_slip_when_locked: assert property (
    @(posedge gt_rxusrclk) disable iff (gt_tx_reset)
    rx_block_lock |-> !serdes_rx_bitslip
  ) else begin
    fail_count++;
    $error("bitslip requested while block lock is held");
  end

  slip_one_cycle: assert property (
    @(posedge gt_rxusrclk) disable iff (gt_tx_reset)
    serdes_rx_bitslip |=> !serdes_rx_bitslip
  ) else begin
    fail_count++;
    $error("bitslip held high for two cycles in a row");
  end

  // Lock needs a full run of good headers before it can rise
  no_early_lock: assert property (
    @(posedge gt_rxusrclk) disable iff (gt_tx_reset)
    $rose(rx_block_lock) |-> (since_reset >= lock_good_count)
  ) else begin
    fail_count++;
    $error("block lock rose before enough headers were seen after reset");
  end

endmodule

bind pcs_block_lock pcs_lane_sva #(
  .lock_good_count (lock_good_count)
) u_lane_sva (
  .gt_rxusrclk       (gt_rxusrclk),
  .gt_tx_reset       (gt_tx_reset),
  .rx_block_lock     (rx_block_lock),
  .serdes_rx_bitslip (serdes_rx_bitslip)
);

/* rtl/pcs_lane_top.sv */
// One 10GBASE-R PCS lane with transmit and receive paths on a single clock
`timescale 1ns/1ns

module pcs_lane_top
  import pcs_pkg::*;
#(
  parameter int lock_good_count = pcs_pkg::lock_good_count,
  parameter int lock_window     = pcs_pkg::lock_window,
  parameter int lock_bad_limit  = pcs_pkg::lock_bad_limit
) (
  input  logic                  gt_rxusrclk,
  input  logic                  gt_tx_reset,
  input  logic [data_width-1:0] xgmii_txd,
  input  logic [ctrl_width-1:0] xgmii_txc,
  output logic [data_width-1:0] serdes_tx_data,
  output logic [hdr_width-1:0]  serdes_tx_hdr,
  input  logic [data_width-1:0] serdes_rx_data,
  input  logic [hdr_width-1:0]  serdes_rx_hdr,
  output logic                  serdes_rx_bitslip,
  output logic                  rx_block_lock,
  output logic [data_width-1:0] xgmii_rxd,
  output logic [ctrl_width-1:0] xgmii_rxc
);

  logic [hdr_width-1:0]  enc_hdr;
  logic [data_width-1:0] enc_data;
  logic [hdr_width-1:0]  dec_hdr;
  logic [data_width-1:0] dec_data;

  // ----------------------------------------------------------
  // Transmit path
  // ----------------------------------------------------------
  pcs_tx_encoder u_tx_encoder (
    .gt_rxusrclk (gt_rxusrclk),
    .gt_tx_reset (gt_tx_reset),
    .xgmii_txd   (xgmii_txd),
    .xgmii_txc   (xgmii_txc),
    .enc_hdr     (enc_hdr),
    .enc_data    (enc_data)
  );

  pcs_scrambler #(
    .DESCRAMBLE (1'b0)
  ) u_scrambler (
    .gt_rxusrclk (gt_rxusrclk),
    .gt_tx_reset (gt_tx_reset),
    .in_hdr      (enc_hdr),
    .in_data     (enc_data),
    .out_hdr     (serdes_tx_hdr),
    .out_data    (serdes_tx_data)
  );

  // ----------------------------------------------------------
  // Receive path
  // ----------------------------------------------------------
  pcs_block_lock #(
    .lock_good_count (lock_good_count),
    .lock_window     (lock_window),
    .lock_bad_limit  (lock_bad_limit)
  ) u_block_lock (
    .gt_rxusrclk       (gt_rxusrclk),
    .gt_tx_reset       (gt_tx_reset),
    .serdes_rx_hdr     (serdes_rx_hdr),
    .rx_block_lock     (rx_block_lock),
    .serdes_rx_bitslip (serdes_rx_bitslip)
  );

  pcs_scrambler #(
    .DESCRAMBLE (1'b1)
  ) u_descrambler (
    .gt_rxusrclk (gt_rxusrclk),
    .gt_tx_reset (gt_tx_reset),
    .in_hdr      (serdes_rx_hdr),
    .in_data     (serdes_rx_data),
    .out_hdr     (dec_hdr),
    .out_data    (dec_data)
  );

  pcs_rx_decoder u_rx_decoder (
    .gt_rxusrclk   (gt_rxusrclk),
    .gt_tx_reset   (gt_tx_reset),
    .dec_hdr       (dec_hdr),
    .dec_data      (dec_data),
    .rx_block_lock (rx_block_lock),
    .xgmii_rxd     (xgmii_rxd),
    .xgmii_rxc     (xgmii_rxc)
  );

endmodule

/* rtl/pcs_rx_decoder.sv */
// Receive decoder that turns a descrambled 66-bit block back into an XGMII word
`timescale 1ns/1ns

module pcs_rx_decoder
  import pcs_pkg::*;
(
  input  logic                  gt_rxusrclk,
  input  logic                  gt_tx_reset,
  input  logic [hdr_width-1:0]  dec_hdr,
  input  logic [data_width-1:0] dec_data,
  input  logic                  rx_block_lock,
  output logic [data_width-1:0] xgmii_rxd,
  output logic [ctrl_width-1:0] xgmii_rxc
);

  block_type_e           blk_type;
  logic [data_width-1:0] rxd_next;
  logic [ctrl_width-1:0] rxc_next;

  assign blk_type = block_type_e'(dec_data[7:0]);

  // ----------------------------------------------------------
  // Block to XGMII mapping
  // ----------------------------------------------------------
  always_comb begin
    // Error word unless the block is recognised under lock
    rxd_next = {ctrl_width{xgmii_error}};
    rxc_next = '1;
    if (rx_block_lock && dec_hdr == hdr_data) begin
      rxd_next = dec_data;
      rxc_next = '0;
    end else if (rx_block_lock && dec_hdr == hdr_ctrl) begin
      case (blk_type)
        bt_ctrl: begin
          for (int j = 0; j < ctrl_width; j++) begin
            rxd_next[8*j +: 8] = (dec_data[8 + 7*j +: 7] == ctrl_idle) ?
                                 xgmii_idle : xgmii_error;
          end
        end

        bt_start0: begin
          rxd_next = {dec_data[data_width-1:8], xgmii_start};
          rxc_next = 8'h01;
        end

        default: begin
          // Terminate types, anything left unmatched stays an error word
          for (int k = 0; k < ctrl_width; k++) begin
            if (dec_data[7:0] == term_type(k)) begin
              rxc_next = {ctrl_width{1'b1}} << k;
              for (int j = 0; j < ctrl_width; j++) begin
                if (j < k) begin
                  rxd_next[8*j +: 8] = dec_data[8 + 8*j +: 8];
                end else if (j == k) begin
                  rxd_next[8*j +: 8] = xgmii_term;
                end else begin
                  rxd_next[8*j +: 8] = (dec_data[8 + 7*j +: 7] == ctrl_idle) ?
                                       xgmii_idle : xgmii_error;
                end
              end
            end
          end
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------
  always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
    if (gt_tx_reset) begin
      xgmii_rxd <= {ctrl_width{xgmii_error}};
      xgmii_rxc <= '1;
    end else begin
      xgmii_rxd <= rxd_next;
      xgmii_rxc <= rxc_next;
    end
  end

endmodule

/* rtl/pcs_block_lock.sv */
// Block lock FSM on receive sync headers with bitslip request while searching
`timescale 1ns/1ns

module pcs_block_lock
  import pcs_pkg::*;
#(
  parameter int lock_good_count = pcs_pkg::lock_good_count,
  parameter int lock_window     = pcs_pkg::lock_window,
  parameter int lock_bad_limit  = pcs_pkg::lock_bad_limit
) (
  input  logic                 gt_rxusrclk,
  input  logic                 gt_tx_reset,
  input  logic [hdr_width-1:0] serdes_rx_hdr,
  output logic                 rx_block_lock,
  output logic                 serdes_rx_bitslip
);

  // One counter serves both states: good headers in search, window position when held
  localparam int cnt_max = (lock_good_count > lock_window) ? lock_good_count : lock_window;
  localparam int cnt_w   = $clog2(cnt_max + 1);
  localparam int bad_w   = $clog2(lock_bad_limit + 1);

  lock_state_e      state;
  logic [cnt_w-1:0] hdr_cnt;
  logic [bad_w-1:0] bad_cnt;
  logic             hdr_valid;

  assign hdr_valid     = (serdes_rx_hdr == hdr_data) || (serdes_rx_hdr == hdr_ctrl);
  assign rx_block_lock = (state == lock_held);

  always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
    if (gt_tx_reset) begin
      state             <= lock_search;
      hdr_cnt           <= '0;
      bad_cnt           <= '0;
      serdes_rx_bitslip <= 1'b0;
    end else begin
      serdes_rx_bitslip <= 1'b0;
      case (state)
        lock_search: begin
          if (!hdr_valid) begin
            hdr_cnt <= '0;
            // The header right after a slip still has the old alignment
            serdes_rx_bitslip <= !serdes_rx_bitslip;
          end else if (hdr_cnt == cnt_w'(lock_good_count - 1)) begin
            state   <= lock_held;
            hdr_cnt <= '0;
            bad_cnt <= '0;
          end else begin
            hdr_cnt <= hdr_cnt + 1'b1;
          end
        end

        lock_held: begin
          if (!hdr_valid && bad_cnt == bad_w'(lock_bad_limit - 1)) begin
            state   <= lock_search;
            hdr_cnt <= '0;
            bad_cnt <= '0;
          end else if (hdr_cnt == cnt_w'(lock_window - 1)) begin
            // Window ends below the limit, start over
            hdr_cnt <= '0;
            bad_cnt <= '0;
          end else begin
            hdr_cnt <= hdr_cnt + 1'b1;
            bad_cnt <= bad_cnt + bad_w'(!hdr_valid);
          end
        end

        default: begin
          state <= lock_search;
        end
      endcase
    end
  end

endmodule

/* rtl/pcs_scrambler.sv */
// Self-synchronous 1 + x^39 + x^58 scrambler or descrambler on 64-bit payloads
`timescale 1ns/1ns

module pcs_scrambler
  import pcs_pkg::*;
#(
  parameter bit DESCRAMBLE = 1'b0
) (
  input  logic                  gt_rxusrclk,
  input  logic                  gt_tx_reset,
  input  logic [hdr_width-1:0]  in_hdr,
  input  logic [data_width-1:0] in_data,
  output logic [hdr_width-1:0]  out_hdr,
  output logic [data_width-1:0] out_data
);

  logic [scr_width-1:0]  state;
  logic [scr_width-1:0]  state_next;
  logic [data_width-1:0] data_next;

  // Bit 0 goes first, state[0] holds the most recent line bit
  always_comb begin
    state_next = state;
    for (int i = 0; i < data_width; i++) begin
      data_next[i] = in_data[i] ^ state_next[38] ^ state_next[57];
      // Line bits feed the state: own output when scrambling, received bit when descrambling
      state_next   = {state_next[scr_width-2:0], DESCRAMBLE ? in_data[i] : data_next[i]};
    end
  end

  always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
    if (gt_tx_reset) begin
      state    <= scr_seed;
      out_hdr  <= '0;
      out_data <= '0;
    end else begin
      state    <= state_next;
      out_hdr  <= in_hdr;
      out_data <= data_next;
    end
  end

endmodule

/* rtl/pcs_tx_encoder.sv */
// Transmit encoder that turns one XGMII word into a 66-bit block per cycle
`timescale 1ns/1ns

module pcs_tx_encoder
  import pcs_pkg::*;
(
  input  logic                  gt_rxusrclk,
  input  logic                  gt_tx_reset,
  input  logic [data_width-1:0] xgmii_txd,
  input  logic [ctrl_width-1:0] xgmii_txc,
  output logic [hdr_width-1:0]  enc_hdr,
  output logic [data_width-1:0] enc_data
);

  logic [hdr_width-1:0]  blk_hdr;
  logic [data_width-1:0] blk_data;
  logic                  is_idle;
  logic                  is_start;

  // True when lane k holds the terminate with data before it and idles after it
  function automatic logic term_at(
    input logic [data_width-1:0] d,
    input logic [ctrl_width-1:0] c,
    input int                    k
  );
    logic ok;
    ok = (c == ({ctrl_width{1'b1}} << k)) && (d[8*k +: 8] == xgmii_term);
    for (int j = k + 1; j < ctrl_width; j++) begin
      ok &= (d[8*j +: 8] == xgmii_idle);
    end
    return ok;
  endfunction

  // ----------------------------------------------------------
  // Word classification
  // ----------------------------------------------------------
  assign is_idle  = (xgmii_txc == '1) && (xgmii_txd == {ctrl_width{xgmii_idle}});
  assign is_start = (xgmii_txc == 8'h01) && (xgmii_txd[7:0] == xgmii_start);

  always_comb begin
    blk_hdr  = hdr_ctrl;
    blk_data = '0;
    if (xgmii_txc == '0) begin
      blk_hdr  = hdr_data;
      blk_data = xgmii_txd;
    end else if (is_idle) begin
      blk_data = {{ctrl_width{ctrl_idle}}, bt_ctrl};
    end else if (is_start) begin
      // Lane 0 start is implied by the block type
      blk_data = {xgmii_txd[data_width-1:8], bt_start0};
    end else begin
      // Default to an error block unless a terminate pattern matches
      blk_data = {{ctrl_width{ctrl_error}}, bt_ctrl};
      for (int k = 0; k < ctrl_width; k++) begin
        if (term_at(xgmii_txd, xgmii_txc, k)) begin
          blk_data      = '0;
          blk_data[7:0] = term_type(k);
          for (int j = 0; j < ctrl_width; j++) begin
            if (j < k) begin
              blk_data[8 + 8*j +: 8] = xgmii_txd[8*j +: 8];
            end else if (j > k) begin
              // Codes after the terminate sit at the same offsets as in a control block
              blk_data[8 + 7*j +: 7] = ctrl_idle;
            end
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------
  always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
    if (gt_tx_reset) begin
      enc_hdr  <= '0;
      enc_data <= '0;
    end else begin
      enc_hdr  <= blk_hdr;
      enc_data <= blk_data;
    end
  end

endmodule

/* rtl/pcs_pkg.sv */
// Shared widths, XGMII characters and 64b/66b block codes for one 10GBASE-R lane
package pcs_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int data_width = 64;
  localparam int ctrl_width = 8;
  localparam int hdr_width  = 2;
  localparam int scr_width  = 58;

  // Sync header values, 2'b00 and 2'b11 are invalid
  localparam logic [hdr_width-1:0] hdr_data = 2'b10;
  localparam logic [hdr_width-1:0] hdr_ctrl = 2'b01;

  // XGMII control characters
  localparam logic [7:0] xgmii_idle  = 8'h07;
  localparam logic [7:0] xgmii_start = 8'hfb;
  localparam logic [7:0] xgmii_term  = 8'hfd;
  localparam logic [7:0] xgmii_error = 8'hfe;

  // 7-bit control codes inside control blocks
  localparam logic [6:0] ctrl_idle  = 7'h00;
  localparam logic [6:0] ctrl_error = 7'h1e;

  typedef enum logic [7:0] {
    bt_ctrl   = 8'h1e,
    bt_start0 = 8'h78,
    bt_term0  = 8'h87,
    bt_term1  = 8'h99,
    bt_term2  = 8'haa,
    bt_term3  = 8'hb4,
    bt_term4  = 8'hcc,
    bt_term5  = 8'hd2,
    bt_term6  = 8'he1,
    bt_term7  = 8'hff
  } block_type_e;

  typedef enum logic {
    lock_search,
    lock_held
  } lock_state_e;

  localparam logic [scr_width-1:0] scr_seed = {scr_width{1'b1}};

  // Block lock defaults
  localparam int lock_good_count = 64;
  localparam int lock_window     = 64;
  localparam int lock_bad_limit  = 16;

  // Terminate block type for the lane that carries the terminate character
  function automatic block_type_e term_type(input int lane);
    case (lane)
      0:       return bt_term0;
      1:       return bt_term1;
      2:       return bt_term2;
      3:       return bt_term3;
      4:       return bt_term4;
      5:       return bt_term5;
      6:       return bt_term6;
      default: return bt_term7;
    endcase
  endfunction

endpackage
